// ==== verilog/cpuBusPkg.sv ====
/*
  CPU-side definitions for the chip bus bridge.
  Covers 68040 transfer sizes, byte-lane masks, the request sampled at
  transfer start and the termination bundle returned to the processor.
*/
`default_nettype none

package cpuBusPkg;

    // Byte offset within the long word, A[1:0]
    typedef logic [1:0] cpuAddrT;

    // 68040 SIZ[1:0]
    typedef logic [1:0] sizeT;

    localparam sizeT SIZ_LONG = 2'b00;
    localparam sizeT SIZ_BYTE = 2'b01;
    localparam sizeT SIZ_WORD = 2'b10;
    // Never seen on register space, decoded as long
    localparam sizeT SIZ_LINE = 2'b11;

    // Active-low byte enables, bit 3 is D31..D24
    typedef logic [3:0] laneMaskT;

    localparam laneMaskT LANES_OFF = 4'b1111;

    // Sampled with TS
    typedef struct packed {
        cpuAddrT addr;
        sizeT    size;
        logic    read;
    } cpuReqT;

    // Idle request, long read at offset 0
    localparam cpuReqT REQ_RESET = '{addr: 2'b00, size: SIZ_LONG, read: 1'b1};

    // TA, TCI and TBI move as one
    typedef struct packed {
        logic tackN;
        logic tciN;
        logic tbiN;
    } cpuTermT;

    localparam cpuTermT TERM_IDLE = 3'b111;
    localparam cpuTermT TERM_ACK  = 3'b000;

endpackage

`default_nettype wire

// ==== verilog/chipRamPkg.sv ====
/*
  Agnus DRAM side and SDRAM command definitions.
  Holds the strobe bundle fed through the synchronizer, the SDRAM command
  encodings and the state type of the chip-RAM controller.
*/
`default_nettype none

package chipRamPkg;

    // Multiplexed row/column from Agnus
    typedef logic [9:0]  draT;
    typedef logic [10:0] sdramAddrT;
    typedef logic [1:0]  bankT;

    typedef struct packed {
        logic csN;
        logic rasN;
        logic casN;
        logic weN;
    } sdramCmdT;

    localparam sdramCmdT CMD_NOP       = 4'b0111;
    localparam sdramCmdT CMD_ACTIVE    = 4'b0011;
    localparam sdramCmdT CMD_READ      = 4'b0101;
    localparam sdramCmdT CMD_WRITE     = 4'b0100;
    localparam sdramCmdT CMD_PRECHARGE = 4'b0010;

    // A10, auto precharge on column cmds, all banks on precharge
    localparam int SDRAM_AP_BIT = 10;

    // Agnus strobes, synchronized together
    typedef struct packed {
        logic ras0N;
        logic ras1N;
        logic casUN;
        logic casLN;
        logic awEN;
    } agnusStrobeT;

    localparam agnusStrobeT STROBES_IDLE = '1;

    // CAS upper drives the even 68040 lanes (0 and 2)
    localparam logic [3:0] CAS_UPPER_LANES = 4'b1010;
    localparam logic [3:0] CAS_LOWER_LANES = 4'b0101;

    typedef enum logic [1:0] {
        RAM_IDLE,
        RAM_ROW_OPEN,
        RAM_ACCESS
    } ramStateT;

endpackage

`default_nettype wire

// ==== verilog/byteLaneDecode.sv ====
/*
  Byte-lane decode for both bridge paths.
  CPU cycles map SIZ and A[1:0] onto the 68040 lanes and the chip bus
  UDS/LDS pair, DMA cycles map the Agnus CAS strobes onto the RAM lanes.
*/
`timescale 1ns/1ps
`default_nettype none

module byteLaneDecode
    import cpuBusPkg::*;
    import chipRamPkg::*;
(
    input  cpuReqT     req,
    input  logic       dmaCycle,
    input  logic       casUN,
    input  logic       casLN,
    output laneMaskT   laneEnN,
    output laneMaskT   ramLaneEnN,
    output logic [1:0] dataStrobeN
);

    // Active-high views, inverted at the outputs
    logic [3:0] laneOn;
    logic [1:0] halfOn;
    logic [3:0] casOn;

    ////////////////////
    // CPU lanes
    ////////////////////

    always_comb begin
        case (req.size)
            // Single lane, offset walks down from D31
            SIZ_BYTE: laneOn = 4'b1000 >> req.addr;
            // Aligned pair, A1 picks the half
            SIZ_WORD: laneOn = req.addr[1] ? 4'b0011 : 4'b1100;
            SIZ_LONG, SIZ_LINE: laneOn = 4'b1111;
            default: laneOn = 4'b1111;
        endcase
    end

    assign laneEnN = ~laneOn;

    // 16-bit chip bus sees only the addressed half
    assign halfOn = req.addr[1] ? laneOn[1:0] : laneOn[3:2];

    // Bit 1 is UDS (even byte), bit 0 is LDS
    assign dataStrobeN = ~halfOn;

    ////////////////////
    // DMA lanes
    ////////////////////

    always_comb begin
        casOn = 4'b0000;
        if (!casUN) begin
            casOn = casOn | CAS_UPPER_LANES;
        end
        if (!casLN) begin
            casOn = casOn | CAS_LOWER_LANES;
        end
    end

    // Quiet outside DMA
    assign ramLaneEnN = dmaCycle ? ~casOn : LANES_OFF;

endmodule

`default_nettype wire

// ==== verilog/registerCycleSm.sv ====
/*
  Chip-register cycle sequencer.
  Takes a 68040 transfer start into register space, waits for the custom
  chips to free the bus, runs one AS/UDS/LDS cycle on a chip clock phase
  and returns TA with TCI and TBI for one clock.
*/
`timescale 1ns/1ps
`default_nettype none

module registerCycleSm
    import cpuBusPkg::*;
(
    input  logic       clk40,
    input  logic       rstN,
    input  logic       c1,
    input  logic       c3,
    input  logic       tsN,
    input  logic       regSpaceN,
    input  logic       dbrN,
    input  cpuReqT     req,
    input  logic [1:0] dataStrobeN,
    output cpuReqT     reqHeld,
    output cpuTermT    term,
    output logic       asN,
    output logic       udsN,
    output logic       ldsN,
    output logic       prwN,
    output logic       regEnN
);

    typedef enum logic [2:0] {
        REG_IDLE,
        REG_WAIT_BUS,
        REG_STROBE,
        REG_RELEASE,
        REG_ACK
    } regStateT;

    regStateT state;
    regStateT stateNext;

    logic phaseNow;
    logic phaseQ;
    logic phaseStart;
    logic strobing;

    ////////////////////
    // Chip clock phase
    ////////////////////

    // C3 up while C1 down marks the phase
    assign phaseNow = c3 & ~c1;

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            phaseQ <= 1'b0;
        end else begin
            phaseQ <= phaseNow;
        end
    end

    // First clk40 of the phase only
    assign phaseStart = phaseNow & ~phaseQ;

    ////////////////////
    // Sequencer
    ////////////////////

    always_comb begin
        stateNext = state;
        case (state)
            REG_IDLE: begin
                // Starts to other spaces belong to someone else
                if (!tsN && !regSpaceN) begin
                    stateNext = REG_WAIT_BUS;
                end
            end
            REG_WAIT_BUS: begin
                // DBR low just stretches this wait
                if (dbrN && phaseStart) begin
                    stateNext = REG_STROBE;
                end
            end
            REG_STROBE: begin
                // Chips latch by the end of the C3 high time
                if (!c3) begin
                    stateNext = REG_RELEASE;
                end
            end
            REG_RELEASE: stateNext = REG_ACK;
            REG_ACK:     stateNext = REG_IDLE;
            default:     stateNext = REG_IDLE;
        endcase
    end

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state   <= REG_IDLE;
            reqHeld <= REQ_RESET;
        end else begin
            state <= stateNext;
            // Freeze the request so the lane decode stays put
            if (state == REG_IDLE && !tsN && !regSpaceN) begin
                reqHeld <= req;
            end
        end
    end

    ////////////////////
    // Bus outputs
    ////////////////////

    assign strobing = (state == REG_STROBE);

    assign asN    = ~strobing;
    assign regEnN = ~strobing;
    assign udsN   = strobing ? dataStrobeN[1] : 1'b1;
    assign ldsN   = strobing ? dataStrobeN[0] : 1'b1;

    // High for reads, parked high between cycles
    assign prwN = strobing ? reqHeld.read : 1'b1;

    // Register space is never cached or burst
    assign term = (state == REG_ACK) ? TERM_ACK : TERM_IDLE;

endmodule

`default_nettype wire

// ==== verilog/chipRamSm.sv ====
/*
  Agnus DRAM strobe to SDRAM command translator for chip RAM DMA.
  Strobes are synchronized into clk40 and each edge becomes one SDRAM
  command three clocks later, with NOP in between.
*/
`timescale 1ns/1ps
`default_nettype none

module chipRamSm
    import chipRamPkg::*;
(
    input  logic      clk40,
    input  logic      rstN,
    input  logic      ras0N,
    input  logic      ras1N,
    input  logic      casUN,
    input  logic      casLN,
    input  logic      awEN,
    input  draT       dra,
    output sdramCmdT  sdramCmd,
    output bankT      bank,
    output sdramAddrT cma,
    output logic      clkEn,
    output logic      dbEnN,
    output logic      dbDir,
    output logic      dmaCycle
);

    agnusStrobeT strobeIn;
    agnusStrobeT syncS1;
    agnusStrobeT syncS2;
    agnusStrobeT syncS3;

    draT draS1;
    draT draS2;
    draT openRow;

    ramStateT state;

    sdramAddrT colAddr;

    logic ras0Fall;
    logic ras1Fall;
    logic rasRise;
    logic casFall;
    logic casIdle;
    logic issueActive;
    logic issueAccess;
    logic issuePrecharge;

    ////////////////////
    // Synchronizers
    ////////////////////

    assign strobeIn = '{ras0N: ras0N, ras1N: ras1N, casUN: casUN, casLN: casLN, awEN: awEN};

    // S1/S2 resolve, S3 only for edges
    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            syncS1 <= STROBES_IDLE;
            syncS2 <= STROBES_IDLE;
            syncS3 <= STROBES_IDLE;
        end else begin
            syncS1 <= strobeIn;
            syncS2 <= syncS1;
            syncS3 <= syncS2;
        end
    end

    // DRA rides alongside so row/column line up with the strobe
    always_ff @(posedge clk40) begin
        draS1 <= dra;
        draS2 <= draS1;
    end

    ////////////////////
    // Edge detect
    ////////////////////

    assign ras0Fall = syncS3.ras0N & ~syncS2.ras0N;
    assign ras1Fall = syncS3.ras1N & ~syncS2.ras1N;
    assign rasRise  = (~syncS3.ras0N & syncS2.ras0N) | (~syncS3.ras1N & syncS2.ras1N);
    assign casFall  = (syncS3.casUN & ~syncS2.casUN) | (syncS3.casLN & ~syncS2.casLN);
    assign casIdle  = syncS3.casUN & syncS3.casLN;

    // RAS fall wins, strobes never pile up anyway
    assign issueActive    = ras0Fall | ras1Fall;
    assign issueAccess    = ~issueActive & casFall & (state != RAM_IDLE);
    assign issuePrecharge = ~issueActive & ~casFall & rasRise & (state != RAM_IDLE);

    ////////////////////
    // Command FSM
    ////////////////////

    always_ff @(posedge clk40 or negedge rstN) begin
        if (!rstN) begin
            state    <= RAM_IDLE;
            sdramCmd <= CMD_NOP;
            bank     <= '0;
            dbDir    <= 1'b0;
        end else begin
            // One-clock commands
            sdramCmd <= CMD_NOP;
            if (issueActive) begin
                sdramCmd <= CMD_ACTIVE;
                // RAS1 selects bank 1
                bank     <= {1'b0, ras1Fall};
                state    <= RAM_ROW_OPEN;
            end else if (issueAccess) begin
                sdramCmd <= syncS2.awEN ? CMD_READ : CMD_WRITE;
                dbDir    <= ~syncS2.awEN;
                state    <= RAM_ACCESS;
            end else if (issuePrecharge) begin
                sdramCmd <= CMD_PRECHARGE;
                state    <= RAM_IDLE;
            end else if (state == RAM_ACCESS && casIdle) begin
                // Page mode, another CAS may follow
                state <= RAM_ROW_OPEN;
            end
        end
    end

    ////////////////////
    // Address path
    ////////////////////

    // Agnus RAS rise closes the row, so no auto precharge
    always_comb begin
        colAddr = sdramAddrT'(draS2);
        colAddr[SDRAM_AP_BIT] = 1'b0;
    end

    always_ff @(posedge clk40) begin
        if (issueActive) begin
            openRow <= draS2;
            cma     <= sdramAddrT'(draS2);
        end else if (issueAccess) begin
            cma <= colAddr;
        end else if (issuePrecharge) begin
            // Single bank precharge, A10 stays low
            cma <= sdramAddrT'(openRow);
        end
    end

    ////////////////////
    // Status outputs
    ////////////////////

    // No power down modes, clock always enabled
    assign clkEn = 1'b1;

    // Data buffers open while either CAS is down
    assign dbEnN = casIdle;

    assign dmaCycle = (state != RAM_IDLE);

endmodule

`default_nettype wire

// ==== verilog/chipBusBridge.sv ====
/*
  Chip bus bridge top level.
  Ties the register cycle sequencer, the byte-lane decode and the
  chip-RAM command translator to the CPU, Agnus and SDRAM pins.
*/
`timescale 1ns/1ps
`default_nettype none

module chipBusBridge
    import cpuBusPkg::*;
    import chipRamPkg::*;
(
    input  logic      clk40,
    input  logic      rstN,
    // Chip clock phases
    input  logic      c1,
    input  logic      c3,
    // CPU transfer
    input  logic      tsN,
    input  logic      regSpaceN,
    input  cpuReqT    req,
    output cpuTermT   term,
    output laneMaskT  laneEnN,
    // Agnus register bus
    input  logic      dbrN,
    output logic      asN,
    output logic      udsN,
    output logic      ldsN,
    output logic      prwN,
    output logic      regEnN,
    // Agnus DRAM strobes
    input  logic      ras0N,
    input  logic      ras1N,
    input  logic      casUN,
    input  logic      casLN,
    input  logic      awEN,
    input  draT       dra,
    output laneMaskT  ramLaneEnN,
    // SDRAM
    output sdramCmdT  sdramCmd,
    output bankT      bank,
    output sdramAddrT cma,
    output logic      clkEn,
    output logic      dbEnN,
    output logic      dbDir
);

    cpuReqT     reqHeld;
    logic [1:0] dataStrobeN;
    logic       dmaCycle;

    ////////////////////
    // Register cycles
    ////////////////////

    registerCycleSm u_regCycle (
        .clk40       (clk40),
        .rstN        (rstN),
        .c1          (c1),
        .c3          (c3),
        .tsN         (tsN),
        .regSpaceN   (regSpaceN),
        .dbrN        (dbrN),
        .req         (req),
        .dataStrobeN (dataStrobeN),
        .reqHeld     (reqHeld),
        .term        (term),
        .asN         (asN),
        .udsN        (udsN),
        .ldsN        (ldsN),
        .prwN        (prwN),
        .regEnN      (regEnN)
    );

    ////////////////////
    // Byte lanes
    ////////////////////

    // Decode works on the held request, stable for the whole cycle
    byteLaneDecode u_laneDecode (
        .req         (reqHeld),
        .dmaCycle    (dmaCycle),
        .casUN       (casUN),
        .casLN       (casLN),
        .laneEnN     (laneEnN),
        .ramLaneEnN  (ramLaneEnN),
        .dataStrobeN (dataStrobeN)
    );

    ////////////////////
    // Chip RAM DMA
    ////////////////////

    chipRamSm u_chipRam (
        .clk40    (clk40),
        .rstN     (rstN),
        .ras0N    (ras0N),
        .ras1N    (ras1N),
        .casUN    (casUN),
        .casLN    (casLN),
        .awEN     (awEN),
        .dra      (dra),
        .sdramCmd (sdramCmd),
        .bank     (bank),
        .cma      (cma),
        .clkEn    (clkEn),
        .dbEnN    (dbEnN),
        .dbDir    (dbDir),
        .dmaCycle (dmaCycle)
    );

endmodule

`default_nettype wire

// ==== test/chipBusBridgeTb.sv ====
/*
  Testbench for the chip bus bridge.
  Runs random register accesses with a random DBR pattern, foreign starts
  and random Agnus RAS/CAS rows, checking against models kept here.
*/
`timescale 1ns/1ps
`default_nettype none

module chipBusBridgeTb
    import cpuBusPkg::*;
    import chipRamPkg::*;
();

    localparam int REG_ACCESSES = 48;
    localparam int DMA_ROWS     = 40;
    localparam int REG_TIMEOUT  = 400;
    localparam int QUIET_CYCLES = 40;

    // One expected SDRAM command and the cycle it must show up in
    typedef struct packed {
        logic [31:0] cycle;
        sdramCmdT    cmd;
        bankT        bank;
        sdramAddrT   addr;
    } expCmdT;

    logic      clk40;
    logic      rstN;
    logic      c1;
    logic      c3;
    logic      tsN;
    logic      regSpaceN;
    cpuReqT    req;
    cpuTermT   term;
    laneMaskT  laneEnN;
    logic      dbrN;
    logic      asN;
    logic      udsN;
    logic      ldsN;
    logic      prwN;
    logic      regEnN;
    logic      ras0N;
    logic      ras1N;
    logic      casUN;
    logic      casLN;
    logic      awEN;
    draT       dra;
    laneMaskT  ramLaneEnN;
    sdramCmdT  sdramCmd;
    bankT      bank;
    sdramAddrT cma;
    logic      clkEn;
    logic      dbEnN;
    logic      dbDir;

    logic [31:0] rngState;
    logic [31:0] cycleCount;
    logic [2:0]  phaseCnt;
    logic        expWrite;
    // Window of cycles where the data buffers must be open
    logic [31:0] dbOnFrom;
    logic [31:0] dbOnUntil;
    int          dbrHold;
    int          errorCount;
    expCmdT      expQ[$];

    chipBusBridge u_chipBusBridge (
        .clk40      (clk40),
        .rstN       (rstN),
        .c1         (c1),
        .c3         (c3),
        .tsN        (tsN),
        .regSpaceN  (regSpaceN),
        .req        (req),
        .term       (term),
        .laneEnN    (laneEnN),
        .dbrN       (dbrN),
        .asN        (asN),
        .udsN       (udsN),
        .ldsN       (ldsN),
        .prwN       (prwN),
        .regEnN     (regEnN),
        .ras0N      (ras0N),
        .ras1N      (ras1N),
        .casUN      (casUN),
        .casLN      (casLN),
        .awEN       (awEN),
        .dra        (dra),
        .ramLaneEnN (ramLaneEnN),
        .sdramCmd   (sdramCmd),
        .bank       (bank),
        .cma        (cma),
        .clkEn      (clkEn),
        .dbEnN      (dbEnN),
        .dbDir      (dbDir)
    );

    ////////////////////
    // Clocks
    ////////////////////

    always #2 clk40 = ~clk40;

    // Chip clock phases, divide by 8, C3 lags C1 by a quarter
    always @(posedge clk40) begin
        #1;
        phaseCnt = phaseCnt + 3'd1;
        c1 = (phaseCnt < 3'd4);
        c3 = (phaseCnt >= 3'd2) && (phaseCnt <= 3'd5);
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] nextRandom();
        logic [31:0] s;
        s = rngState;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        rngState = s;
        return s;
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
            abortRun();
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic nextCycle();
        @(posedge clk40);
        #1;
        cycleCount = cycleCount + 32'd1;
    endtask

    // 68040 lane table, active low, bit 3 is D31..D24
    function automatic laneMaskT modelLanes(input cpuReqT r);
        laneMaskT m;
        m = 4'b0000;
        if (r.size == SIZ_BYTE) begin
            case (r.addr)
                2'd0:    m = 4'b0111;
                2'd1:    m = 4'b1011;
                2'd2:    m = 4'b1101;
                default: m = 4'b1110;
            endcase
        end else if (r.size == SIZ_WORD) begin
            m = r.addr[1] ? 4'b1100 : 4'b0011;
        end
        return m;
    endfunction

    // {udsN, ldsN}, byte cycles use one half, even address on UDS
    function automatic logic [1:0] modelStrobes(input cpuReqT r);
        if (r.size == SIZ_BYTE) begin
            return r.addr[0] ? 2'b10 : 2'b01;
        end
        return 2'b00;
    endfunction

    function automatic cpuReqT randomReq();
        logic [31:0] r;
        r = nextRandom();
        return cpuReqT'(r[4:0]);
    endfunction

    // Chips grab the bus for random stretches
    task automatic driveDbr();
        logic [31:0] r;
        r = nextRandom();
        if (dbrHold > 0) begin
            dbrHold--;
        end else if (r[1:0] == 2'b00) begin
            dbrN = 1'b0;
            dbrHold = 1 + int'(r[7:4] % 4'd12);
        end else begin
            dbrN = 1'b1;
            dbrHold = int'(r[10:8] % 3'd6);
        end
    endtask

    ////////////////////
    // Register path
    ////////////////////

    task automatic regAccess(input cpuReqT r);
        int   waited;
        logic ackSeen;
        logic strobeSeen;
        logic asPrev;
        logic dbrPrev;
        waited = 0;
        ackSeen = 1'b0;
        strobeSeen = 1'b0;
        asPrev = 1'b1;
        dbrPrev = dbrN;
        tsN = 1'b0;
        regSpaceN = 1'b0;
        req = r;
        nextCycle();
        // Request must be held inside, so scramble the pins
        tsN = 1'b1;
        regSpaceN = 1'b1;
        req = randomReq();
        while (!ackSeen && waited < REG_TIMEOUT) begin
            driveDbr();
            @(negedge clk40);
            if (asPrev && !asN) begin
                checkEqual("dbrN at asN fall", 32'(dbrPrev), 32'd1);
            end
            if (!asN) begin
                strobeSeen = 1'b1;
                checkEqual("regEnN", 32'(regEnN), 32'd0);
                checkEqual("prwN", 32'(prwN), 32'(r.read));
                checkEqual("udsN/ldsN", 32'({udsN, ldsN}), 32'(modelStrobes(r)));
            end else begin
                checkEqual("idle strobes", 32'({udsN, ldsN, regEnN}), 32'h7);
            end
            if (term !== TERM_IDLE) begin
                ackSeen = 1'b1;
                checkEqual("termination", 32'(term), 32'(TERM_ACK));
                checkEqual("strobe before ack", 32'(strobeSeen), 32'd1);
                checkEqual("laneEnN", 32'(laneEnN), 32'(modelLanes(r)));
            end
            asPrev = asN;
            dbrPrev = dbrN;
            nextCycle();
            waited++;
        end
        if (!ackSeen) begin
            $display("No acknowledge for a register access after %0d cycles", waited);
            abortRun();
        end
        // Pulse lasts exactly one clock
        @(negedge clk40);
        checkEqual("termination after ack", 32'(term), 32'(TERM_IDLE));
        checkEqual("asN after ack", 32'(asN), 32'd1);
        nextCycle();
    endtask

    // Start outside register space, nobody answers
    task automatic foreignStart();
        tsN = 1'b0;
        regSpaceN = 1'b1;
        req = randomReq();
        nextCycle();
        tsN = 1'b1;
        repeat (QUIET_CYCLES) begin
            driveDbr();
            @(negedge clk40);
            checkEqual("foreign termination", 32'(term), 32'(TERM_IDLE));
            checkEqual("foreign asN", 32'(asN), 32'd1);
            nextCycle();
        end
    endtask

    ////////////////////
    // DMA path
    ////////////////////

    // Command due three clocks after the strobe just driven
    task automatic expectCmd(input sdramCmdT cmd, input bankT b, input sdramAddrT a);
        expCmdT e;
        e.cycle = cycleCount + 32'd3;
        e.cmd = cmd;
        e.bank = b;
        e.addr = a;
        expQ.push_back(e);
    endtask

    task automatic dmaRun(input int n);
        expCmdT e;
        logic   expDbEnN;
        repeat (n) begin
            @(negedge clk40);
            // CAS upper on lanes 3 and 1
            checkEqual("ramLaneEnN", 32'(ramLaneEnN), 32'({casUN, casLN, casUN, casLN}));
            // Buffers follow the CAS strobes after the synchronizer
            expDbEnN = !(cycleCount >= dbOnFrom && cycleCount < dbOnUntil);
            checkEqual("dbEnN", 32'(dbEnN), 32'(expDbEnN));
            if (!dbEnN) begin
                checkEqual("dbDir", 32'(dbDir), 32'(expWrite));
            end
            if (expQ.size() != 0 && expQ[0].cycle == cycleCount) begin
                e = expQ.pop_front();
                checkEqual("sdramCmd", 32'(sdramCmd), 32'(e.cmd));
                checkEqual("bank", 32'(bank), 32'(e.bank));
                checkEqual("cma", 32'(cma), 32'(e.addr));
            end else begin
                checkEqual("sdramCmd between strobes", 32'(sdramCmd), 32'(CMD_NOP));
            end
            nextCycle();
        end
    endtask

    // Strobes at least 5 clocks apart
    function automatic int randomGap();
        logic [31:0] r;
        r = nextRandom();
        return 5 + int'(r[1:0]);
    endfunction

    task automatic dmaRow();
        logic [31:0] r;
        draT  row;
        draT  col;
        bankT b;
        logic write;
        r = nextRandom();
        row = r[9:0];
        col = r[19:10];
        b = {1'b0, r[20]};
        write = r[21];
        // Row open
        dra = row;
        if (b[0]) begin
            ras1N = 1'b0;
        end else begin
            ras0N = 1'b0;
        end
        expectCmd(CMD_ACTIVE, b, sdramAddrT'(row));
        dmaRun(randomGap());
        // Column access, at least one CAS
        dra = col;
        awEN = ~write;
        expWrite = write;
        casUN = (r[23:22] == 2'b01);
        casLN = (r[23:22] == 2'b10);
        dbOnFrom = cycleCount + 32'd3;
        dbOnUntil = 32'hffff_ffff;
        expectCmd(write ? CMD_WRITE : CMD_READ, b, sdramAddrT'(col));
        dmaRun(randomGap());
        casUN = 1'b1;
        casLN = 1'b1;
        dbOnUntil = cycleCount + 32'd3;
        dmaRun(randomGap());
        // Row close, A10 low, row address kept
        awEN = 1'b1;
        ras0N = 1'b1;
        ras1N = 1'b1;
        expectCmd(CMD_PRECHARGE, b, sdramAddrT'(row));
        dmaRun(randomGap());
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        int i;
        rngState = 32'd76094;
        cycleCount = 32'd0;
        errorCount = 0;
        dbrHold = 0;
        expWrite = 1'b0;
        dbOnFrom = 32'd0;
        dbOnUntil = 32'd0;
        phaseCnt = 3'd0;
        clk40 = 1'b0;
        rstN = 1'b0;
        c1 = 1'b1;
        c3 = 1'b0;
        tsN = 1'b1;
        regSpaceN = 1'b1;
        req = REQ_RESET;
        dbrN = 1'b1;
        ras0N = 1'b1;
        ras1N = 1'b1;
        casUN = 1'b1;
        casLN = 1'b1;
        awEN = 1'b1;
        dra = '0;

        repeat (10) @(posedge clk40);
        #1;
        rstN = 1'b1;

        // Everything parked after reset
        @(negedge clk40);
        checkEqual("term after reset", 32'(term), 32'(TERM_IDLE));
        checkEqual("bus strobes after reset", 32'({asN, udsN, ldsN, prwN, regEnN}), 32'h1f);
        checkEqual("sdramCmd after reset", 32'(sdramCmd), 32'(CMD_NOP));
        checkEqual("dbEnN after reset", 32'(dbEnN), 32'd1);
        checkEqual("clkEn after reset", 32'(clkEn), 32'd1);
        nextCycle();

        for (i = 0; i < REG_ACCESSES; i++) begin
            regAccess(randomReq());
            if (i % 8 == 7) begin
                foreignStart();
            end
        end

        dbrN = 1'b1;
        for (i = 0; i < DMA_ROWS; i++) begin
            dmaRow();
        end
        checkEqual("missing SDRAM commands", 32'(expQ.size()), 32'd0);

        if (errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/cpuBusPkg.sv
verilog/chipRamPkg.sv
verilog/byteLaneDecode.sv
verilog/registerCycleSm.sv
verilog/chipRamSm.sv
verilog/chipBusBridge.sv
test/chipBusBridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the chip bus bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing -f verilog.f --top-module chipBusBridgeTb \
    && ./obj_dir/VchipBusBridgeTb; } > sim.log 2>&1 \
    || echo "Test failed" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
echo "Simulation passed"
exit 0
